// ==== filelist.f ====
logic/weight_pkg.sv
logic/instruc_fifo.sv
logic/reader_fsm.sv
logic/address_counter.sv
logic/weight_store.sv
logic/beat_fifo.sv
logic/weight_reader_top.sv
tb/tb_clock.sv
tb/weight_reader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

TOP=weight_reader_tb
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" -o "$TOP"

status=0
./obj_dir/"$TOP" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation PASSED"

// ==== tb/weight_reader_tb.sv ====
`timescale 1ns/1ps

module weight_reader_tb;

    localparam int INSTR_DEPTH = 4;
    localparam int OUT_DEPTH   = 8;
    localparam int NUM_TESTS   = 7;
    localparam int WORDS       = 2 ** weight_pkg::ADDR_W;

    // Stimulus table row with a stall bit for random back-pressure
    typedef struct packed {
        weight_pkg::instruc_t instr;
        logic                 stall;
    } test_entry_t;

    logic                          clk;
    logic                          resetn;
    logic                          instruc_valid;
    logic                          instruc_ready;
    weight_pkg::instruc_t          instruc;
    logic                          wr_valid;
    logic                          wr_ready;
    logic [weight_pkg::DATA_W-1:0] wr_data;
    logic                          start;
    logic                          q_valid;
    logic                          q_ready;
    weight_pkg::read_beat_t        q;

    test_entry_t                   tests [NUM_TESTS];
    logic [weight_pkg::DATA_W-1:0] weights [WORDS];
    logic [weight_pkg::ADDR_W-1:0] exp_addr [$];
    weight_pkg::beat_info_t        exp_info [$];
    int                            exp_test [$];
    integer                        seed = 32'h3c07_9799;
    int                            cycles = 0;
    int                            cycle_limit = 0;

    tb_clock u_tb_clock (.clk);

    weight_reader_top #(
        .INSTR_DEPTH(INSTR_DEPTH),
        .OUT_DEPTH  (OUT_DEPTH)
    ) u_weight_reader_top (
        .clk,
        .resetn,
        .instruc_valid,
        .instruc_ready,
        .instruc,
        .wr_valid,
        .wr_ready,
        .wr_data,
        .start,
        .q_valid,
        .q_ready,
        .q
    );

    function automatic test_entry_t make_entry(input int s0, input int s1, input int s2,
                                               input int t0, input int t1, input int t2,
                                               input int off, input logic stall);
        test_entry_t e;
        e.instr.sizes[0]   = 8'(s0);
        e.instr.sizes[1]   = 8'(s1);
        e.instr.sizes[2]   = 8'(s2);
        e.instr.strides[0] = 8'(t0);
        e.instr.strides[1] = 8'(t1);
        e.instr.strides[2] = 8'(t2);
        e.instr.offset     = 8'(off);
        e.stall            = stall;
        return e;
    endfunction

    task automatic fill_table();
        // Unit strides from 0, so words come back in store order
        tests[0] = make_entry(4, 4, 2, 1, 4, 16, 0, 1'b0);
        // Sum runs past 255 and wraps
        tests[1] = make_entry(4, 3, 2, 5, 17, 100, 200, 1'b0);
        tests[2] = make_entry(1, 1, 1, 0, 0, 0, 77, 1'b0);
        tests[3] = make_entry(3, 2, 4, 2, 9, 30, 250, 1'b0);
        tests[4] = make_entry(8, 2, 2, 1, 8, 16, 128, 1'b1);
        tests[5] = make_entry(5, 3, 3, 3, 1, 50, 10, 1'b1);
        tests[6] = make_entry(2, 5, 2, 255, 7, 3, 5, 1'b1);
    endtask

    // Walk every instruction with digit 0 fastest
    task automatic expand_expected();
        int s0;
        int s1;
        int s2;
        int sum;
        weight_pkg::beat_info_t info;
        for (int t = 0; t < NUM_TESTS; t++) begin
            s0 = int'(tests[t].instr.sizes[0]);
            s1 = int'(tests[t].instr.sizes[1]);
            s2 = int'(tests[t].instr.sizes[2]);
            for (int c2 = 0; c2 < s2; c2++) begin
                for (int c1 = 0; c1 < s1; c1++) begin
                    for (int c0 = 0; c0 < s0; c0++) begin
                        sum = int'(tests[t].instr.offset)
                            + c0 * int'(tests[t].instr.strides[0])
                            + c1 * int'(tests[t].instr.strides[1])
                            + c2 * int'(tests[t].instr.strides[2]);
                        info.last_elm    = (c0 == s0 - 1) && (c1 == s1 - 1) && (c2 == s2 - 1);
                        info.last_inner  = (c0 == s0 - 1);
                        info.first_outer = (c2 == 0);
                        exp_addr.push_back(8'(sum));
                        exp_info.push_back(info);
                        exp_test.push_back(t);
                    end
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Write stream is always ready once out of reset
    task automatic write_weights();
        for (int i = 0; i < WORDS; i++) begin
            @(negedge clk);
            weights[i] = $random(seed);
            wr_valid   = 1'b1;
            wr_data    = weights[i];
            check_value("wr_ready", 64'(wr_ready), 64'd1);
        end
        @(negedge clk);
        wr_valid = 1'b0;
        wr_data  = '0;
    endtask

    task automatic queue_instructions();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            instruc_valid = 1'b1;
            instruc       = tests[t].instr;
            while (!instruc_ready) @(negedge clk);
        end
        @(negedge clk);
        instruc_valid = 1'b0;
        instruc       = '0;
    endtask

    // Outputs only move on the rising edge, so the falling edge sees them settled
    task automatic receive_beats();
        int idx;
        int rnd;
        idx = 0;
        while (idx < exp_addr.size()) begin
            @(negedge clk);
            if (tests[exp_test[idx]].stall) begin
                rnd     = $random(seed);
                q_ready = rnd[0];
            end else begin
                q_ready = 1'b1;
            end
            if (q_valid && q_ready) begin
                check_value($sformatf("q.data[%0d]", idx), 64'(q.data),
                            64'(weights[exp_addr[idx]]));
                check_value($sformatf("q.info[%0d]", idx), 64'(q.info), 64'(exp_info[idx]));
                idx++;
            end
        end
        @(negedge clk);
        q_ready = 1'b1;
        // Nothing may follow the final beat
        repeat (10) begin
            @(negedge clk);
            check_value("q_valid", 64'(q_valid), 64'd0);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        resetn        = 1'b0;
        instruc_valid = 1'b0;
        instruc       = '0;
        wr_valid      = 1'b0;
        wr_data       = '0;
        start         = 1'b0;
        q_ready       = 1'b0;
        fill_table();
        expand_expected();
        cycle_limit = 256 + 4 * exp_addr.size() + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value("instruc_ready", 64'(instruc_ready), 64'd0);
        check_value("q_valid", 64'(q_valid), 64'd0);
        resetn = 1'b1;
        @(negedge clk);
        check_value("instruc_ready", 64'(instruc_ready), 64'd1);
        write_weights();
        fork
            queue_instructions();
            begin
                // Instructions are queued but the reader has not been started
                repeat (20) begin
                    @(negedge clk);
                    check_value("q_valid", 64'(q_valid), 64'd0);
                end
                // More instructions than slots, so the queue is full by now
                check_value("instruc_ready", 64'(instruc_ready), 64'd0);
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
                receive_beats();
            end
        join
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== logic/weight_reader_top.sv ====
`timescale 1ns/1ps

module weight_reader_top #(
    parameter int INSTR_DEPTH = 4,
    parameter int OUT_DEPTH   = 8
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          instruc_valid,
    output logic                          instruc_ready,
    input  weight_pkg::instruc_t          instruc,
    input  logic                          wr_valid,
    output logic                          wr_ready,
    input  logic [weight_pkg::DATA_W-1:0] wr_data,
    input  logic                          start,
    output logic                          q_valid,
    input  logic                          q_ready,
    output weight_pkg::read_beat_t        q
);

    weight_pkg::instruc_t                 instruc_q;
    weight_pkg::read_req_t                req;
    weight_pkg::read_beat_t               beat;
    logic                                 empty;
    logic                                 load;
    logic                                 issue;
    logic                                 at_last_elm;
    logic                                 beat_valid;
    logic [$clog2(OUT_DEPTH + 1)-1:0]     occupancy;

    instruc_fifo #(.INSTR_DEPTH(INSTR_DEPTH)) u_instruc_fifo (
        .clk,
        .resetn,
        .instruc_valid,
        .instruc_ready,
        .instruc,
        .load,
        .empty,
        .instruc_q
    );

    reader_fsm #(.OUT_DEPTH(OUT_DEPTH)) u_reader_fsm (
        .clk,
        .resetn,
        .start,
        .empty,
        .at_last_elm,
        .occupancy,
        .load,
        .issue
    );

    address_counter u_address_counter (
        .clk,
        .resetn,
        .load,
        .instruc_q,
        .issue,
        .req,
        .at_last_elm
    );

    weight_store u_weight_store (
        .clk,
        .resetn,
        .wr_valid,
        .wr_ready,
        .wr_data,
        .issue,
        .req,
        .beat_valid,
        .beat
    );

    beat_fifo #(.OUT_DEPTH(OUT_DEPTH)) u_beat_fifo (
        .clk,
        .resetn,
        .beat_valid,
        .beat,
        .q_valid,
        .q_ready,
        .q,
        .occupancy
    );

endmodule

// ==== logic/beat_fifo.sv ====
`timescale 1ns/1ps

module beat_fifo #(
    parameter int OUT_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             beat_valid,
    input  weight_pkg::read_beat_t           beat,
    output logic                             q_valid,
    input  logic                             q_ready,
    output weight_pkg::read_beat_t           q,
    output logic [$clog2(OUT_DEPTH + 1)-1:0] occupancy
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    weight_pkg::read_beat_t entries [OUT_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   pop;

    // Head entry is visible without a read strobe
    assign q_valid   = (count != '0);
    assign q         = entries[rd_ptr];
    assign pop       = q_valid && q_ready;
    assign occupancy = count;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (beat_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(beat_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            entries[wr_ptr] <= beat;
        end
    end

    // Issue gating upstream must leave room for every returning word
    assert property (@(posedge clk) disable iff (!resetn)
        beat_valid |-> count < CNT_W'(OUT_DEPTH));

endmodule

// ==== logic/weight_store.sv ====
`timescale 1ns/1ps

module weight_store (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               wr_valid,
    output logic                               wr_ready,
    input  logic [weight_pkg::DATA_W-1:0]      wr_data,
    input  logic                               issue,
    input  weight_pkg::read_req_t              req,
    output logic                               beat_valid,
    output weight_pkg::read_beat_t             beat
);

    localparam int WORDS = 2 ** weight_pkg::ADDR_W;

    logic [weight_pkg::DATA_W-1:0] mem [WORDS];
    logic [weight_pkg::ADDR_W-1:0] wr_ptr;
    logic                          wr_en;

    assign wr_en = wr_valid && wr_ready;

    // Sequential loading with a pointer that wraps after the last word
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ready   <= 1'b0;
            wr_ptr     <= '0;
            beat_valid <= 1'b0;
        end else begin
            wr_ready   <= 1'b1;
            beat_valid <= issue;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Flags ride alongside the registered read
    always_ff @(posedge clk) begin
        if (issue) begin
            beat.data <= mem[req.addr];
            beat.info <= req.info;
        end
    end

endmodule

// ==== logic/address_counter.sv ====
`timescale 1ns/1ps

module address_counter (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  load,
    input  weight_pkg::instruc_t  instruc_q,
    input  logic                  issue,
    output weight_pkg::read_req_t req,
    output logic                  at_last_elm
);

    localparam int N = weight_pkg::NUM_DIGITS;
    localparam int A = weight_pkg::ADDR_W;

    weight_pkg::instruc_t  instr;
    weight_pkg::digits_t   counts;
    logic [N-1:0]          at_last;
    logic [N-1:0]          at_first;
    logic [N-1:0]          carry;
    logic [A-1:0]          addr_sum;

    // Active instruction, held for the whole walk
    always_ff @(posedge clk) begin
        if (load) begin
            instr <= instruc_q;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            at_last[i]  = (counts[i] == instr.sizes[i] - 1'b1);
            at_first[i] = (counts[i] == '0);
        end
    end

    // Digit i steps only when all faster digits wrap
    always_comb begin
        carry[0] = issue;
        for (int i = 1; i < N; i++) begin
            carry[i] = carry[i-1] && at_last[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            counts <= '0;
        end else if (load) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (carry[i]) begin
                    counts[i] <= at_last[i] ? '0 : counts[i] + 1'b1;
                end
            end
        end
    end

    // Address wraps at the store size
    always_comb begin
        addr_sum = A'(instr.offset);
        for (int i = 0; i < N; i++) begin
            addr_sum = addr_sum + A'(counts[i] * instr.strides[i]);
        end
    end

    assign at_last_elm = &at_last;

    always_comb begin
        req.addr             = addr_sum;
        req.info.last_elm    = &at_last;
        req.info.last_inner  = at_last[0];
        req.info.first_outer = at_first[N-1];
    end

    // Every digit stays below its size while reads go out
    assert property (@(posedge clk) disable iff (!resetn)
        issue |-> (counts[0] < instr.sizes[0]) && (counts[1] < instr.sizes[1])
                  && (counts[2] < instr.sizes[2]));

endmodule

// ==== logic/reader_fsm.sv ====
`timescale 1ns/1ps

module reader_fsm #(
    parameter int OUT_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             start,
    input  logic                             empty,
    input  logic                             at_last_elm,
    input  logic [$clog2(OUT_DEPTH + 1)-1:0] occupancy,
    output logic                             load,
    output logic                             issue
);

    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    weight_pkg::reader_state_e state;
    weight_pkg::reader_state_e next_state;
    logic                      in_flight;
    logic [CNT_W:0]            pending;

    // One read sits in the store register before it lands in the FIFO
    assign pending = (CNT_W + 1)'(occupancy) + (CNT_W + 1)'(in_flight);

    assign load  = (state == weight_pkg::GET_INSTRUC) && !empty;
    assign issue = (state == weight_pkg::COUNT) && (pending < (CNT_W + 1)'(OUT_DEPTH));

    always_comb begin
        next_state = state;
        case (state)
            weight_pkg::IDLE: begin
                if (start) next_state = weight_pkg::GET_INSTRUC;
            end
            weight_pkg::GET_INSTRUC: begin
                if (load) next_state = weight_pkg::COUNT;
            end
            weight_pkg::COUNT: begin
                if (issue && at_last_elm) next_state = weight_pkg::GET_INSTRUC;
            end
            default: next_state = weight_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= weight_pkg::IDLE;
            in_flight <= 1'b0;
        end else begin
            state     <= next_state;
            in_flight <= issue;
        end
    end

    // Stored words plus the one in flight never exceed the FIFO depth
    assert property (@(posedge clk) disable iff (!resetn)
        pending <= (CNT_W + 1)'(OUT_DEPTH));

endmodule

// ==== logic/instruc_fifo.sv ====
`timescale 1ns/1ps

module instruc_fifo #(
    parameter int INSTR_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 instruc_valid,
    output logic                 instruc_ready,
    input  weight_pkg::instruc_t instruc,
    input  logic                 load,
    output logic                 empty,
    output weight_pkg::instruc_t instruc_q
);

    localparam int PTR_W = (INSTR_DEPTH > 1) ? $clog2(INSTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(INSTR_DEPTH + 1);

    weight_pkg::instruc_t entries [INSTR_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 out_of_reset;
    logic                 push;

    assign instruc_ready = out_of_reset && (count != CNT_W'(INSTR_DEPTH));
    assign empty         = (count == '0);
    assign push          = instruc_valid && instruc_ready;
    assign instruc_q     = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_of_reset <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
        end else begin
            out_of_reset <= 1'b1;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= (rd_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(load);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= instruc;
        end
    end

    // Counter logic relies on every digit having at least one value
    assert property (@(posedge clk) disable iff (!resetn)
        push |-> (instruc.sizes[0] != '0) && (instruc.sizes[1] != '0)
                 && (instruc.sizes[2] != '0));

    assert property (@(posedge clk) disable iff (!resetn) load |-> !empty);

endmodule

// ==== logic/weight_pkg.sv ====
package weight_pkg;

    // Counter digits
    localparam int DIGIT_W    = 8;
    localparam int NUM_DIGITS = 3;

    // Weight words and store addressing
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;

    typedef logic [DIGIT_W-1:0] digit_t;

    // Digit 0 sits in the low byte and counts fastest
    typedef logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits_t;

    typedef struct packed {
        digits_t sizes;
        digits_t strides;
        digit_t  offset;
    } instruc_t;

    // Tile flags carried with every word
    typedef struct packed {
        logic last_elm;
        logic last_inner;
        logic first_outer;
    } beat_info_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        beat_info_t        info;
    } read_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        beat_info_t        info;
    } read_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        GET_INSTRUC,
        COUNT
    } reader_state_e;

endpackage
